//--- source/dmem_pkg.sv
// data memory package
// widths, cache geometry and the enums that the
// data cache, the miss handler and the memory side share
//
// addresses are byte addresses, blocks hold two words

package dmem_pkg;

    ////////////////////
    // widths
    ////////////////////

    localparam int ADDR_BITS    = 16;   // byte address
    localparam int WORD_BITS    = 32;
    localparam int BLOCK_BITS   = 64;   // one memory block, two words
    localparam int MEM_TAG_BITS = 4;    // zero means no transaction

    ////////////////////
    // cache geometry
    ////////////////////

    localparam int OFFSET_BITS = 3;     // byte offset within a block
    localparam int CACHE_LINES = 32;
    localparam int INDEX_BITS  = 5;
    localparam int TAG_BITS    = ADDR_BITS - INDEX_BITS - OFFSET_BITS;  // 8

    ////////////////////
    // types
    ////////////////////

    typedef logic [ADDR_BITS-1:0]    addr_t;
    typedef logic [WORD_BITS-1:0]    word_t;
    typedef logic [BLOCK_BITS-1:0]   block_t;
    typedef logic [MEM_TAG_BITS-1:0] mem_tag_t;

    // command toward the tagged memory
    typedef enum logic [1:0] {
        MEM_NONE  = 2'd0,
        MEM_LOAD  = 2'd1,
        MEM_STORE = 2'd2
    } mem_command_e;

    // miss handler states
    typedef enum logic [1:0] {
        IDLE      = 2'd0,   // ready for a request
        SEND      = 2'd1,   // command out, retried until memory takes it
        WAIT_DATA = 2'd2,   // waiting for the matching data tag
        FILL      = 2'd3    // one cycle line write
    } miss_state_e;

endpackage

//--- source/dcache_array.sv
// data cache array
// direct-mapped, 32 lines of one 64-bit block each
// hit is combinational from the request address; stores that hit
// update their word, fills write the whole line, and the load word
// comes out registered one cycle after accept or fill

`timescale 1ns/10ps

module dcache_array (
    input  logic                 clock,
    input  logic                 reset,

    input  logic                 accept,     // request taken this cycle
    input  logic                 req_store,
    input  dmem_pkg::addr_t      req_addr,
    input  dmem_pkg::word_t      req_data,
    output logic                 hit,

    input  logic                 fill_en,
    input  dmem_pkg::addr_t      fill_addr,
    input  dmem_pkg::block_t     fill_block,

    output logic                 ld_valid,
    output dmem_pkg::word_t      ld_data
);

    // word within a block picked by the top offset bit
    function automatic dmem_pkg::word_t pick_word(
        input dmem_pkg::block_t blk,
        input logic             sel
    );
        if (sel) begin
            pick_word = blk[dmem_pkg::BLOCK_BITS-1 -: dmem_pkg::WORD_BITS];
        end else begin
            pick_word = blk[dmem_pkg::WORD_BITS-1:0];
        end
    endfunction

    ////////////////////
    // storage
    ////////////////////

    logic [dmem_pkg::CACHE_LINES-1:0] valid_q;
    logic [dmem_pkg::TAG_BITS-1:0]    tag_mem  [dmem_pkg::CACHE_LINES];
    dmem_pkg::block_t                 data_mem [dmem_pkg::CACHE_LINES];

    // address split
    logic [dmem_pkg::INDEX_BITS-1:0] req_index;
    logic [dmem_pkg::TAG_BITS-1:0]   req_tag;
    logic                            req_sel;
    logic [dmem_pkg::INDEX_BITS-1:0] fill_index;
    logic [dmem_pkg::TAG_BITS-1:0]   fill_tag;

    assign req_index  = req_addr[dmem_pkg::OFFSET_BITS +: dmem_pkg::INDEX_BITS];
    assign req_tag    = req_addr[dmem_pkg::ADDR_BITS-1 -: dmem_pkg::TAG_BITS];
    assign req_sel    = req_addr[dmem_pkg::OFFSET_BITS-1];
    assign fill_index = fill_addr[dmem_pkg::OFFSET_BITS +: dmem_pkg::INDEX_BITS];
    assign fill_tag   = fill_addr[dmem_pkg::ADDR_BITS-1 -: dmem_pkg::TAG_BITS];

    ////////////////////
    // lookup
    ////////////////////

    assign hit = valid_q[req_index] && (tag_mem[req_index] == req_tag);

    logic store_hit;
    logic load_hit;

    assign store_hit = accept && req_store && hit;
    assign load_hit  = accept && !req_store && hit;

    ////////////////////
    // line updates
    ////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            valid_q <= '0;                      // every line invalid
        end else if (fill_en) begin
            valid_q[fill_index] <= 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (fill_en) begin
            tag_mem[fill_index]  <= fill_tag;
            data_mem[fill_index] <= fill_block;
        end else if (store_hit) begin
            // write-through, so only the addressed word changes here
            if (req_sel) begin
                data_mem[req_index][dmem_pkg::BLOCK_BITS-1 -: dmem_pkg::WORD_BITS] <= req_data;
            end else begin
                data_mem[req_index][dmem_pkg::WORD_BITS-1:0] <= req_data;
            end
        end
    end

    ////////////////////
    // load result
    ////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            ld_valid <= 1'b0;
        end else begin
            ld_valid <= load_hit || fill_en;    // one cycle pulse
        end
    end

    // result word
    always_ff @(posedge clock) begin
        if (fill_en) begin
            ld_data <= pick_word(fill_block, fill_addr[dmem_pkg::OFFSET_BITS-1]);
        end else if (load_hit) begin
            ld_data <= pick_word(data_mem[req_index], req_sel);
        end
    end

endmodule

//--- source/miss_handler.sv
// miss handler
// takes one request at a time, sends load misses and all stores to the
// tagged memory, holds a refused command until memory takes it, then
// waits for the data tag of a load and hands the block to the cache
// for a single fill cycle

`timescale 1ns/10ps

module miss_handler (
    input  logic                    clock,
    input  logic                    reset,

    // request port
    input  logic                    req_valid,
    input  logic                    req_store,
    input  dmem_pkg::addr_t         req_addr,
    input  dmem_pkg::word_t         req_data,

    // cache side
    input  logic                    hit,
    output logic                    accept,
    output logic                    busy,
    output logic                    fill_en,
    output dmem_pkg::addr_t         fill_addr,
    output dmem_pkg::block_t        fill_block,

    // memory side
    output dmem_pkg::mem_command_e  proc2mem_command,
    output dmem_pkg::addr_t         proc2mem_addr,
    output dmem_pkg::block_t        proc2mem_data,
    input  dmem_pkg::mem_tag_t      mem2proc_transaction_tag,
    input  dmem_pkg::mem_tag_t      mem2proc_data_tag,
    input  dmem_pkg::block_t        mem2proc_data
);

    dmem_pkg::miss_state_e state;
    dmem_pkg::miss_state_e state_next;

    // captured request
    dmem_pkg::addr_t    addr_q;
    dmem_pkg::word_t    data_q;
    logic               store_q;
    dmem_pkg::mem_tag_t tag_q;          // transaction tag of the load
    dmem_pkg::block_t   block_q;        // returned block

    logic mem_taken;
    logic data_match;

    assign accept     = req_valid && (state == dmem_pkg::IDLE);
    assign busy       = (state != dmem_pkg::IDLE);
    assign mem_taken  = (mem2proc_transaction_tag != '0);
    assign data_match = (mem2proc_data_tag == tag_q);

    ////////////////////
    // next state
    ////////////////////

    always_comb begin
        state_next = state;
        unique case (state)
            dmem_pkg::IDLE: begin
                // load hits are served by the cache alone
                if (accept && (req_store || !hit)) begin
                    state_next = dmem_pkg::SEND;
                end
            end
            dmem_pkg::SEND: begin
                if (mem_taken) begin
                    state_next = store_q ? dmem_pkg::IDLE : dmem_pkg::WAIT_DATA;
                end
            end
            dmem_pkg::WAIT_DATA: begin
                if (data_match) begin
                    state_next = dmem_pkg::FILL;
                end
            end
            dmem_pkg::FILL: begin
                state_next = dmem_pkg::IDLE;
            end
            default: begin
                state_next = dmem_pkg::IDLE;
            end
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= dmem_pkg::IDLE;
        end else begin
            state <= state_next;
        end
    end

    ////////////////////
    // captures
    ////////////////////

    always_ff @(posedge clock) begin
        if (accept) begin
            addr_q  <= req_addr;
            data_q  <= req_data;
            store_q <= req_store;
        end
        if ((state == dmem_pkg::SEND) && mem_taken) begin
            tag_q <= mem2proc_transaction_tag;
        end
        if ((state == dmem_pkg::WAIT_DATA) && data_match) begin
            block_q <= mem2proc_data;
        end
    end

    ////////////////////
    // memory command
    ////////////////////

    // held steady through SEND, so a refusal just repeats it
    always_comb begin
        proc2mem_command = dmem_pkg::MEM_NONE;
        proc2mem_addr    = '0;
        proc2mem_data    = '0;
        if (state == dmem_pkg::SEND) begin
            if (store_q) begin
                proc2mem_command = dmem_pkg::MEM_STORE;
                proc2mem_addr    = addr_q;                          // word address
                proc2mem_data    = {{dmem_pkg::WORD_BITS{1'b0}}, data_q};
            end else begin
                proc2mem_command = dmem_pkg::MEM_LOAD;
                proc2mem_addr    = {addr_q[dmem_pkg::ADDR_BITS-1:dmem_pkg::OFFSET_BITS],
                                    {dmem_pkg::OFFSET_BITS{1'b0}}};  // block aligned
            end
        end
    end

    // fill toward the cache
    assign fill_en    = (state == dmem_pkg::FILL);
    assign fill_addr  = addr_q;
    assign fill_block = block_q;

endmodule

//--- source/dmem_top.sv
// data memory top
// joins the processor request port to the cache array and the
// miss handler, and the memory command, address and data ports
// to the miss handler

`timescale 1ns/10ps

module dmem_top (
    input  logic                    clock,
    input  logic                    reset,

    // processor side
    input  logic                    req_valid,
    input  logic                    req_store,
    input  dmem_pkg::addr_t         req_addr,
    input  dmem_pkg::word_t         req_data,
    output logic                    busy,
    output logic                    ld_valid,
    output dmem_pkg::word_t         ld_data,

    // memory side
    output dmem_pkg::mem_command_e  proc2mem_command,
    output dmem_pkg::addr_t         proc2mem_addr,
    output dmem_pkg::block_t        proc2mem_data,
    input  dmem_pkg::mem_tag_t      mem2proc_transaction_tag,
    input  dmem_pkg::mem_tag_t      mem2proc_data_tag,
    input  dmem_pkg::block_t        mem2proc_data
);

    // cache <-> miss handler
    logic             hit;
    logic             accept;
    logic             fill_en;
    dmem_pkg::addr_t  fill_addr;
    dmem_pkg::block_t fill_block;

    miss_handler miss_handler_i (
        .clock                    (clock),
        .reset                    (reset),
        .req_valid                (req_valid),
        .req_store                (req_store),
        .req_addr                 (req_addr),
        .req_data                 (req_data),
        .hit                      (hit),
        .accept                   (accept),
        .busy                     (busy),
        .fill_en                  (fill_en),
        .fill_addr                (fill_addr),
        .fill_block               (fill_block),
        .proc2mem_command         (proc2mem_command),
        .proc2mem_addr            (proc2mem_addr),
        .proc2mem_data            (proc2mem_data),
        .mem2proc_transaction_tag (mem2proc_transaction_tag),
        .mem2proc_data_tag        (mem2proc_data_tag),
        .mem2proc_data            (mem2proc_data)
    );

    dcache_array dcache_array_i (
        .clock      (clock),
        .reset      (reset),
        .accept     (accept),
        .req_store  (req_store),
        .req_addr   (req_addr),
        .req_data   (req_data),
        .hit        (hit),
        .fill_en    (fill_en),
        .fill_addr  (fill_addr),
        .fill_block (fill_block),
        .ld_valid   (ld_valid),
        .ld_data    (ld_data)
    );

endmodule

//--- tests/mem_model.sv
// tagged memory model
// refuses some commands, hands out transaction tags 1 to 15 in turn,
// writes stores at once and returns load blocks after a varying delay
// every word starts as its word address xor 32'h5a5a0000

`timescale 1ns/10ps

module mem_model (
    input  logic                    clock,
    input  logic                    reset,
    input  dmem_pkg::mem_command_e  proc2mem_command,
    input  dmem_pkg::addr_t         proc2mem_addr,
    input  dmem_pkg::block_t        proc2mem_data,
    output dmem_pkg::mem_tag_t      mem2proc_transaction_tag,
    output dmem_pkg::mem_tag_t      mem2proc_data_tag,
    output dmem_pkg::block_t        mem2proc_data
);

    localparam int WORDS = 1 << (dmem_pkg::ADDR_BITS - 2);

    dmem_pkg::word_t    words [WORDS];
    logic [31:0]        lfsr;
    logic               refuse_q;       // refuse whatever comes this cycle
    dmem_pkg::mem_tag_t next_tag;
    dmem_pkg::addr_t    pend_addr;
    int unsigned        pend_count;     // zero when no load is pending
    logic [2:0]         delay_bits;

    // fibonacci lfsr with taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    assign mem2proc_transaction_tag =
        ((proc2mem_command != dmem_pkg::MEM_NONE) && !refuse_q) ? next_tag : '0;

    always @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < WORDS; i++) begin
                words[i] = 32'(i) ^ 32'h5a5a0000;
            end
            lfsr              = 32'h7908;
            refuse_q          <= 1'b0;
            next_tag          <= 4'd1;
            pend_count        <= 0;
            mem2proc_data_tag <= '0;
            mem2proc_data     <= '0;
        end else begin
            mem2proc_data_tag <= '0;            // data tag is a one cycle pulse
            if (mem2proc_transaction_tag != '0) begin
                next_tag <= (next_tag == 4'd15) ? 4'd1 : next_tag + 4'd1;
                if (proc2mem_command == dmem_pkg::MEM_STORE) begin
                    words[proc2mem_addr[dmem_pkg::ADDR_BITS-1:2]] = proc2mem_data[31:0];
                end else begin
                    for (int b = 0; b < 3; b++) begin
                        lfsr          = lfsr_step(lfsr);
                        delay_bits[b] = lfsr[0];
                    end
                    pend_count <= (delay_bits > 3'd6) ? 8 : 32'(delay_bits) + 2;
                    pend_addr  <= proc2mem_addr;
                end
            end
            if (pend_count == 1) begin
                mem2proc_data_tag <= next_tag - 4'd1 == 4'd0 ? 4'd15 : next_tag - 4'd1;
                mem2proc_data     <= {words[{pend_addr[dmem_pkg::ADDR_BITS-1:3], 1'b1}],
                                      words[{pend_addr[dmem_pkg::ADDR_BITS-1:3], 1'b0}]};
            end
            if (pend_count != 0) begin
                pend_count <= pend_count - 1;
            end
            lfsr     = lfsr_step(lfsr);
            refuse_q <= lfsr[0];
        end
    end

endmodule

//--- tests/dmem_chk.sv
// port protocol checker for the data memory top
// bound to the top level, flags protocol breaks through its assertions

`timescale 1ns/10ps

module dmem_chk (
    input logic                    clock,
    input logic                    reset,
    input logic                    req_store,
    input logic                    accept,
    input logic                    hit,
    input logic                    busy,
    input logic                    ld_valid,
    input dmem_pkg::mem_command_e  proc2mem_command,
    input dmem_pkg::addr_t         proc2mem_addr,
    input dmem_pkg::mem_tag_t      mem2proc_transaction_tag
);

    int unsigned fails = 0;     // assertion failures so far

    ld_while_idle: assert property (@(posedge clock) disable iff (reset)
        ld_valid |-> !busy)
        else begin
            $error("ld_valid raised while busy");
            fails++;
        end

    // refused command comes back unchanged
    refused_held: assert property (@(posedge clock) disable iff (reset)
        (proc2mem_command != dmem_pkg::MEM_NONE && mem2proc_transaction_tag == '0)
        |=> (proc2mem_command == $past(proc2mem_command)
             && proc2mem_addr == $past(proc2mem_addr)))
        else begin
            $error("refused memory command was not held");
            fails++;
        end

    no_cmd_idle: assert property (@(posedge clock) disable iff (reset)
        !busy |-> proc2mem_command == dmem_pkg::MEM_NONE)
        else begin
            $error("memory command issued while not busy");
            fails++;
        end

    hit_latency: assert property (@(posedge clock) disable iff (reset)
        (accept && !req_store && hit) |=> ld_valid)
        else begin
            $error("load hit did not return in the next cycle");
            fails++;
        end

endmodule

//--- tests/dmem_tb.sv
// data memory testbench
// applies a table of loads and stores to the cache and the tagged
// memory model, checks every load word against a shadow memory

`timescale 1ns/10ps

module dmem_tb;

    localparam logic [1:0] ANY_LAT  = 2'd0;    // latency not checked
    localparam logic [1:0] HIT_LAT  = 2'd1;
    localparam logic [1:0] MISS_LAT = 2'd2;
    localparam int WAIT_LIMIT  = 400;
    localparam int RANDOM_ROWS = 240;

    logic                   clock;
    logic                   reset;
    logic                   req_valid;
    logic                   req_store;
    dmem_pkg::addr_t        req_addr;
    dmem_pkg::word_t        req_data;
    logic                   busy;
    logic                   ld_valid;
    dmem_pkg::word_t        ld_data;
    dmem_pkg::mem_command_e proc2mem_command;
    dmem_pkg::addr_t        proc2mem_addr;
    dmem_pkg::block_t       proc2mem_data;
    dmem_pkg::mem_tag_t     mem2proc_transaction_tag;
    dmem_pkg::mem_tag_t     mem2proc_data_tag;
    dmem_pkg::block_t       mem2proc_data;

    ////////////////////
    // table, shadow, counters
    ////////////////////

    logic            row_store [$];
    dmem_pkg::addr_t row_addr [$];
    dmem_pkg::word_t row_data [$];
    logic [1:0]      row_lat [$];          // expected load latency class

    dmem_pkg::word_t shadow [dmem_pkg::addr_t];
    logic [31:0]     lfsr_state;
    int              mismatches;
    int              timeouts;
    int              checks;

    dmem_top dmem_top_i (
        .clock                    (clock),
        .reset                    (reset),
        .req_valid                (req_valid),
        .req_store                (req_store),
        .req_addr                 (req_addr),
        .req_data                 (req_data),
        .busy                     (busy),
        .ld_valid                 (ld_valid),
        .ld_data                  (ld_data),
        .proc2mem_command         (proc2mem_command),
        .proc2mem_addr            (proc2mem_addr),
        .proc2mem_data            (proc2mem_data),
        .mem2proc_transaction_tag (mem2proc_transaction_tag),
        .mem2proc_data_tag        (mem2proc_data_tag),
        .mem2proc_data            (mem2proc_data)
    );

    mem_model mem_model_i (
        .clock                    (clock),
        .reset                    (reset),
        .proc2mem_command         (proc2mem_command),
        .proc2mem_addr            (proc2mem_addr),
        .proc2mem_data            (proc2mem_data),
        .mem2proc_transaction_tag (mem2proc_transaction_tag),
        .mem2proc_data_tag        (mem2proc_data_tag),
        .mem2proc_data            (mem2proc_data)
    );

    bind dmem_top dmem_chk dmem_chk_i (
        .clock                    (clock),
        .reset                    (reset),
        .req_store                (req_store),
        .accept                   (accept),
        .hit                      (hit),
        .busy                     (busy),
        .ld_valid                 (ld_valid),
        .proc2mem_command         (proc2mem_command),
        .proc2mem_addr            (proc2mem_addr),
        .mem2proc_transaction_tag (mem2proc_transaction_tag)
    );

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    ////////////////////
    // helpers
    ////////////////////

    task automatic compare_value(input string what, input logic [31:0] got,
                                 input logic [31:0] expected);
        checks++;
        if (got !== expected) begin
            $display("Mismatch at %0t: %s, got %h expected %h", $time, what, got, expected);
            mismatches++;
        end
    endtask

    // fibonacci lfsr with taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // one lfsr step per bit taken
    task automatic draw_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int k = 0; k < n; k++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
    endtask

    task automatic add_row(input logic store, input dmem_pkg::addr_t addr,
                           input dmem_pkg::word_t data, input logic [1:0] lat);
        row_store.push_back(store);
        row_addr.push_back(addr);
        row_data.push_back(data);
        row_lat.push_back(lat);
    endtask

    // untouched words hold their word address xor a fixed pattern
    function automatic dmem_pkg::word_t shadow_word(input dmem_pkg::addr_t a);
        if (shadow.exists(a)) begin
            return shadow[a];
        end
        return 32'(a[dmem_pkg::ADDR_BITS-1:2]) ^ 32'h5a5a0000;
    endfunction

    task automatic fill_table();
        logic [31:0] r_op;
        logic [31:0] r_addr;
        logic [31:0] r_data;
        add_row(1'b0, 16'h0100, '0, MISS_LAT);          // cold miss
        add_row(1'b0, 16'h0104, '0, HIT_LAT);           // other word of the same line
        add_row(1'b1, 16'h0104, 32'hdeadbeef, ANY_LAT); // store hit
        add_row(1'b0, 16'h0104, '0, HIT_LAT);
        add_row(1'b0, 16'h0100, '0, HIT_LAT);
        add_row(1'b1, 16'h0208, 32'h12345678, ANY_LAT); // no allocate
        add_row(1'b0, 16'h0208, '0, MISS_LAT);
        add_row(1'b0, 16'h0010, '0, MISS_LAT);          // two tags on index 2
        add_row(1'b0, 16'h1010, '0, MISS_LAT);
        add_row(1'b0, 16'h0014, '0, MISS_LAT);
        add_row(1'b0, 16'h1014, '0, MISS_LAT);
        add_row(1'b0, 16'h1010, '0, HIT_LAT);
        for (int k = 0; k < RANDOM_ROWS; k++) begin
            draw_bits(2, r_op);
            draw_bits(6, r_addr);                       // 2 tag, 3 index and 1 word bits
            draw_bits(32, r_data);
            add_row(r_op[1:0] == 2'b11,
                    {6'b0, r_addr[5:4], 2'b00, r_addr[3:1], r_addr[0], 2'b00},
                    r_data, ANY_LAT);
        end
    endtask

    task automatic run_row(input int idx);
        int                     n;
        logic                   first_busy;
        dmem_pkg::mem_command_e first_cmd;
        req_valid = 1'b1;
        req_store = row_store[idx];
        req_addr  = row_addr[idx];
        req_data  = row_data[idx];
        @(negedge clock);
        req_valid  = 1'b0;
        first_busy = busy;
        first_cmd  = proc2mem_command;
        n          = 1;
        if (row_store[idx]) begin
            compare_value("busy after store accept", 32'(first_busy), 32'd1);
            while (busy && n < WAIT_LIMIT) begin
                @(negedge clock);
                n++;
            end
            if (busy) begin
                $display("store at row %0d never finished, busy stayed high", idx);
                timeouts++;
            end
            shadow[row_addr[idx]] = row_data[idx];
        end else begin
            while (!ld_valid && n < WAIT_LIMIT) begin
                @(negedge clock);
                n++;
            end
            if (!ld_valid) begin
                $display("load at row %0d never returned a word", idx);
                timeouts++;
            end else begin
                compare_value($sformatf("load word, row %0d", idx), ld_data,
                              shadow_word(row_addr[idx]));
                compare_value("busy with ld_valid", 32'(busy), 32'd0);
                if (row_lat[idx] == HIT_LAT) begin
                    compare_value("hit latency", 32'(n), 32'd1);
                    compare_value("command on hit", 32'(first_cmd), 32'(dmem_pkg::MEM_NONE));
                end else if (row_lat[idx] == MISS_LAT) begin
                    compare_value("busy after miss accept", 32'(first_busy), 32'd1);
                end
            end
        end
    endtask

    ////////////////////
    // main sequence
    ////////////////////

    initial begin
        mismatches = 0;
        timeouts   = 0;
        checks     = 0;
        lfsr_state = 32'h7908;
        reset      = 1'b1;
        req_valid  = 1'b0;
        req_store  = 1'b0;
        req_addr   = '0;
        req_data   = '0;
        fill_table();
        repeat (3) @(negedge clock);
        reset = 1'b0;
        @(negedge clock);
        compare_value("busy after reset", 32'(busy), 32'd0);
        compare_value("ld_valid after reset", 32'(ld_valid), 32'd0);
        compare_value("command after reset", 32'(proc2mem_command), 32'(dmem_pkg::MEM_NONE));
        for (int row = 0; row < row_addr.size() && timeouts == 0; row++) begin
            run_row(row);
        end
        $display("%0d checks, %0d mismatches, %0d timeouts, %0d assertion failures",
                 checks, mismatches, timeouts, dmem_top_i.dmem_chk_i.fails);
        if (mismatches == 0 && timeouts == 0 && dmem_top_i.dmem_chk_i.fails == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

//--- vlog.f
source/dmem_pkg.sv
source/dcache_array.sv
source/miss_handler.sv
source/dmem_top.sv
tests/mem_model.sv
tests/dmem_chk.sv
tests/dmem_tb.sv

//--- Makefile
# Verilator build and run for the data memory testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= dmem_tb
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the simulation, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx "Test OK" $(LOG) || (echo "simulation did not pass"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
